/* source/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// core clock in Hz.
`define UART_CLK_FREQ 100000000

// serial bit rate.
`define UART_BAUD 6250000

// entries in each of the transmit and receive FIFOs.
`define UART_FIFO_DEPTH 4

`define UART_CLKS_PER_BIT (`UART_CLK_FREQ / `UART_BAUD)

`endif

/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // address bit 0 selects the register.
    localparam logic ADDR_STATUS = 1'b0;
    localparam logic ADDR_DATA = 1'b1;

    typedef struct packed {
        logic rd;
        logic wr;
        logic addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        byte_t data;
        logic frame_err;
    } rx_entry_t;

    // bit 0 is tx_not_full, bit 1 rx_not_empty, bit 2 the head frame error.
    typedef struct packed {
        logic [28:0] reserved;
        logic rx_frame_err;
        logic rx_not_empty;
        logic tx_not_full;
    } uart_status_t;

endpackage

`default_nettype wire

/* source/uart_fifo.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  wr,
    input  wire T din,
    input  wire  rd,
    output T     dout,
    output logic full,
    output logic empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_wr;
    logic do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CW'(DEPTH));
    assign empty = (count == '0);

    // writes while full and reads while empty are dropped.
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // head entry is always visible.
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_tx (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire uart_pkg::byte_t data,
    output logic                 txd,
    output logic                 busy
);

    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW = (CPB > 1) ? $clog2(CPB) : 1;

    logic [CW-1:0] clk_cnt;
    // 0 is the start bit, 1 to 8 the data, 9 the stop bit.
    logic [3:0] bit_idx;
    byte_t shreg;

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            shreg <= data;
        end else if (busy && clk_cnt == CW'(CPB - 1) && bit_idx < 4'd8) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd <= 1'b1;
            busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (start) begin
                // start bit goes out right away.
                txd <= 1'b0;
                busy <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (clk_cnt == CW'(CPB - 1)) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx < 4'd8) begin
                    txd <= shreg[0];
                end else begin
                    txd <= 1'b1;
                end
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_rx (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rxd,
    output logic                     valid,
    output uart_pkg::rx_entry_t      entry
);

    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int CW = (CPB > 1) ? $clog2(CPB) : 1;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;
    logic fall;
    logic [CW-1:0] clk_cnt;
    logic [2:0] bit_idx;
    byte_t shreg;

    // two flops against metastability, a third for edge detection.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall = rxd_prev && !rxd_sync;

    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == CW'(CPB - 1)) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
        if (state == RX_STOP && clk_cnt == CW'(CPB - 1)) begin
            entry.data <= shreg;
            entry.frame_err <= !rxd_sync;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RX_IDLE;
            valid <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == CW'(HALF - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // a glitch that is high again at mid-bit is ignored.
                        state <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CW'(CPB - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CW'(CPB - 1)) begin
                        valid <= 1'b1;
                        state <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/uart_controller.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_controller (
    input  wire                     clk,
    input  wire                     rst,
    input  wire uart_pkg::bus_req_t req,
    output uart_pkg::word_t         data_rd,
    output logic                    irq,
    input  wire                     rxd,
    output logic                    txd
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_WAIT
    } tx_state_t;

    tx_state_t tx_state;

    logic tx_wr;
    byte_t tx_din;
    byte_t tx_head;
    logic tx_full;
    logic tx_empty;
    logic tx_pop;
    logic tx_busy;

    logic rx_valid;
    rx_entry_t rx_entry;
    logic rx_wr;
    logic rx_rd;
    rx_entry_t rx_head;
    logic rx_full;
    logic rx_empty;

    uart_status_t status;

    // accepted writes reach the FIFO one cycle after the strobe.
    always_ff @(posedge clk) begin
        tx_din <= req.wdata[7:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_wr <= 1'b0;
        end else begin
            tx_wr <= req.wr && (req.addr == ADDR_DATA) && !tx_full;
        end
    end

    uart_fifo #(
        .T(byte_t),
        .DEPTH(`UART_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk,
        .rst,
        .wr(tx_wr),
        .din(tx_din),
        .rd(tx_pop),
        .dout(tx_head),
        .full(tx_full),
        .empty(tx_empty)
    );

    // the head byte is handed over in the same cycle it is popped.
    assign tx_pop = (tx_state == TX_IDLE) && !tx_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_state <= TX_IDLE;
        end else begin
            case (tx_state)
                TX_IDLE: if (!tx_empty) tx_state <= TX_SEND;
                TX_SEND: tx_state <= TX_WAIT;
                TX_WAIT: if (!tx_busy) tx_state <= TX_IDLE;
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    uart_tx u_tx (
        .clk,
        .rst,
        .start(tx_pop),
        .data(tx_head),
        .txd,
        .busy(tx_busy)
    );

    uart_rx u_rx (
        .clk,
        .rst,
        .rxd,
        .valid(rx_valid),
        .entry(rx_entry)
    );

    // frames that arrive while full are lost.
    assign rx_wr = rx_valid && !rx_full;
    assign rx_rd = req.rd && (req.addr == ADDR_DATA) && !rx_empty;

    uart_fifo #(
        .T(rx_entry_t),
        .DEPTH(`UART_FIFO_DEPTH)
    ) u_rx_fifo (
        .clk,
        .rst,
        .wr(rx_wr),
        .din(rx_entry),
        .rd(rx_rd),
        .dout(rx_head),
        .full(rx_full),
        .empty(rx_empty)
    );

    always_comb begin
        status = '0;
        status.tx_not_full = !tx_full;
        status.rx_not_empty = !rx_empty;
        status.rx_frame_err = !rx_empty && rx_head.frame_err;
    end

    // data read while empty keeps the previous value.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_rd <= '0;
        end else if (req.rd) begin
            if (req.addr == ADDR_STATUS) begin
                data_rd <= word_t'(status);
            end else if (!rx_empty) begin
                data_rd <= word_t'(rx_head.data);
            end
        end
    end

    assign irq = !rx_empty;

endmodule

`default_nettype wire

/* sim/uart_checker.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire uart_pkg::bus_req_t req,
    input  wire uart_pkg::word_t    data_rd,
    input  wire                     irq,
    input  wire                     rxd,
    input  wire                     txd,
    output logic                    tx_idle,
    output int                      data_errs,
    output int                      txd_errs,
    output int                      other_errs
);

    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int DEPTH = `UART_FIFO_DEPTH;

    // state of one serial line decoder.
    typedef struct packed {
        logic prev;
        logic active;
        logic [7:0] cnt;
        logic [3:0] idx;
        byte_t data;
        logic stop;
    } decoder_t;

    decoder_t txdec;
    decoder_t rxdec;
    byte_t tx_q[$];
    rx_entry_t rx_q[$];
    byte_t tx_exp;
    logic tx_exp_valid;
    word_t exp_rd;
    logic rd_pending;
    logic reset_checked;

    // idx 0 is the start bit, 1 to 8 the data bits, 9 the stop bit.
    task automatic step_decoder(input logic line, inout decoder_t d,
                                output logic started, output logic done,
                                output logic glitch);
        started = 1'b0;
        done = 1'b0;
        glitch = 1'b0;
        if (!d.active) begin
            if (d.prev && !line) begin
                d.active = 1'b1;
                d.cnt = '0;
                d.idx = '0;
                started = 1'b1;
            end
        end else begin
            d.cnt = d.cnt + 8'd1;
            if (d.idx == 4'd0) begin
                if (d.cnt == 8'(CPB / 2)) begin
                    d.cnt = '0;
                    d.idx = 4'd1;
                    if (line) begin
                        d.active = 1'b0;
                        glitch = 1'b1;
                    end
                end
            end else if (d.cnt == 8'(CPB)) begin
                d.cnt = '0;
                if (d.idx <= 4'd8) begin
                    d.data = {line, d.data[7:1]};
                    d.idx = d.idx + 4'd1;
                end else begin
                    d.stop = line;
                    d.active = 1'b0;
                    done = 1'b1;
                end
            end
        end
        d.prev = line;
    endtask

    task automatic check_reset_outputs();
        if (txd !== 1'b1 || rxd !== 1'b1) begin
            $display("** Error txd/rxd after reset: expected 1/1, got %h/%h", txd, rxd);
            other_errs = other_errs + 1;
        end
        if (irq !== 1'b0) begin
            $display("** Error irq after reset: expected 0, got %h", irq);
            other_errs = other_errs + 1;
        end
        if (data_rd !== '0) begin
            $display("** Error data_rd after reset: expected %08h, got %08h", 32'h0, data_rd);
            data_errs = data_errs + 1;
        end
    endtask

    always @(posedge clk) begin
        logic started;
        logic done;
        logic glitch;
        uart_status_t st;
        rx_entry_t entry;
        if (rst) begin
            tx_q.delete();
            rx_q.delete();
            txdec = '0;
            txdec.prev = 1'b1;
            rxdec = '0;
            rxdec.prev = 1'b1;
            tx_exp = '0;
            tx_exp_valid = 1'b0;
            exp_rd = '0;
            rd_pending = 1'b0;
            reset_checked = 1'b0;
            data_errs = 0;
            txd_errs = 0;
            other_errs = 0;
        end else begin
            if (!reset_checked) begin
                check_reset_outputs();
                reset_checked = 1'b1;
            end
            // read data lands one cycle after the strobe.
            if (rd_pending) begin
                rd_pending = 1'b0;
                if (data_rd !== exp_rd) begin
                    $display("** Error data_rd: expected %08h, got %08h", exp_rd, data_rd);
                    data_errs = data_errs + 1;
                end
            end
            if (req.wr && req.addr == ADDR_DATA && tx_q.size() < DEPTH) begin
                tx_q.push_back(req.wdata[7:0]);
            end
            if (req.rd) begin
                if (irq !== (rx_q.size() != 0)) begin
                    $display("** Error irq: expected %h, got %h", rx_q.size() != 0, irq);
                    other_errs = other_errs + 1;
                end
                if (req.addr == ADDR_STATUS) begin
                    st = '0;
                    st.tx_not_full = (tx_q.size() < DEPTH);
                    st.rx_not_empty = (rx_q.size() != 0);
                    if (rx_q.size() != 0) begin
                        entry = rx_q[0];
                        st.rx_frame_err = entry.frame_err;
                    end
                    exp_rd = word_t'(st);
                end else if (rx_q.size() != 0) begin
                    entry = rx_q.pop_front();
                    exp_rd = word_t'(entry.data);
                end
                rd_pending = 1'b1;
            end

            step_decoder(txd, txdec, started, done, glitch);
            if (started) begin
                tx_exp_valid = (tx_q.size() != 0);
                if (tx_exp_valid) begin
                    tx_exp = tx_q.pop_front();
                end else begin
                    $display("txd started a frame that no accepted write asked for");
                    txd_errs = txd_errs + 1;
                end
            end
            if (glitch) begin
                $display("txd start bit went high again before mid-bit");
                txd_errs = txd_errs + 1;
            end
            if (done && tx_exp_valid) begin
                if (txdec.data !== tx_exp) begin
                    $display("** Error txd data: expected %02h, got %02h", tx_exp, txdec.data);
                    txd_errs = txd_errs + 1;
                end
                if (txdec.stop !== 1'b1) begin
                    $display("** Error txd stop bit: expected 1, got %h", txdec.stop);
                    txd_errs = txd_errs + 1;
                end
                tx_exp_valid = 1'b0;
            end

            step_decoder(rxd, rxdec, started, done, glitch);
            // frames that find the receive FIFO full are lost.
            if (done && rx_q.size() < DEPTH) begin
                entry.data = rxdec.data;
                entry.frame_err = !rxdec.stop;
                rx_q.push_back(entry);
            end
        end
        tx_idle = (tx_q.size() == 0) && !txdec.active;
    end

endmodule

`default_nettype wire

/* sim/tb_uart.sv */
`default_nettype none

`include "uart_cfg.svh"

module tb_uart;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int DEPTH = `UART_FIFO_DEPTH;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_SEND_GOOD,
        OP_SEND_BAD,
        OP_READ_STATUS,
        OP_READ_DATA,
        OP_WAIT_IDLE
    } op_t;

    typedef struct packed {
        op_t op;
        byte_t value;
    } step_t;

    logic clk;
    logic rst;
    bus_req_t req;
    word_t data_rd;
    logic irq;
    logic rxd;
    logic txd;
    logic tx_idle;
    int data_errs;
    int txd_errs;
    int other_errs;

    step_t steps[$];
    logic [31:0] rand_state;
    int cycles = 0;
    int cycle_limit = 0;

    uart_controller u_dut (
        .clk,
        .rst,
        .req,
        .data_rd,
        .irq,
        .rxd,
        .txd
    );

    uart_checker u_checker (
        .clk,
        .rst,
        .req,
        .data_rd,
        .irq,
        .rxd,
        .txd,
        .tx_idle,
        .data_errs,
        .txd_errs,
        .other_errs
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_step(input op_t op, input byte_t value);
        step_t s;
        s.op = op;
        s.value = value;
        steps.push_back(s);
    endtask

    task automatic build_table();
        int i;
        // status after reset, then three bytes out on txd.
        add_step(OP_READ_STATUS, 8'h00);
        add_step(OP_WRITE, 8'h55);
        add_step(OP_WRITE, 8'hA3);
        add_step(OP_WRITE, 8'h0F);
        add_step(OP_WAIT_IDLE, 8'h00);
        // two frames in, read back with status in between.
        add_step(OP_SEND_GOOD, 8'h3C);
        add_step(OP_SEND_GOOD, 8'h81);
        add_step(OP_READ_STATUS, 8'h00);
        add_step(OP_READ_DATA, 8'h00);
        add_step(OP_READ_STATUS, 8'h00);
        add_step(OP_READ_DATA, 8'h00);
        add_step(OP_READ_STATUS, 8'h00);
        // overflow of the receive FIFO.
        for (i = 0; i < DEPTH + 2; i++) begin
            add_step(OP_SEND_GOOD, 8'(8'h10 + 8'(i) * 8'h11));
        end
        for (i = 0; i < DEPTH + 2; i++) begin
            add_step(OP_READ_DATA, 8'h00);
        end
        add_step(OP_READ_STATUS, 8'h00);
        // frame error at the head, then a good frame behind it.
        add_step(OP_SEND_BAD, 8'hE7);
        add_step(OP_SEND_GOOD, 8'h42);
        add_step(OP_READ_STATUS, 8'h00);
        add_step(OP_READ_DATA, 8'h00);
        add_step(OP_READ_STATUS, 8'h00);
        add_step(OP_READ_DATA, 8'h00);
        add_step(OP_READ_STATUS, 8'h00);
        // random burst into the idle transmitter.
        for (i = 0; i < DEPTH; i++) begin
            rand_state = next_random(rand_state);
            add_step(OP_WRITE, rand_state[7:0]);
        end
        add_step(OP_WAIT_IDLE, 8'h00);
    endtask

    task automatic bus_write(input byte_t value);
        @(negedge clk);
        req.wr = 1'b1;
        req.addr = ADDR_DATA;
        req.wdata = {24'h0, value};
        @(negedge clk);
        req = '0;
    endtask

    task automatic bus_read(input logic addr);
        @(negedge clk);
        req.rd = 1'b1;
        req.addr = addr;
        @(negedge clk);
        req = '0;
    endtask

    // start bit, data LSB first, stop bit, then one idle bit.
    task automatic send_frame(input byte_t value, input logic stop_bit);
        logic [10:0] bits;
        int i;
        bits = {1'b1, stop_bit, value, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(negedge clk);
            rxd = bits[i];
            repeat (CPB - 1) @(negedge clk);
        end
    endtask

    task automatic wait_tx_idle();
        @(negedge clk);
        while (!tx_idle) begin
            @(negedge clk);
        end
        repeat (2 * CPB) @(negedge clk);
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            OP_WRITE: bus_write(s.value);
            OP_SEND_GOOD: send_frame(s.value, 1'b1);
            OP_SEND_BAD: send_frame(s.value, 1'b0);
            OP_READ_STATUS: bus_read(ADDR_STATUS);
            OP_READ_DATA: bus_read(ADDR_DATA);
            default: wait_tx_idle();
        endcase
    endtask

    initial begin
        int i;
        rst = 1'b1;
        req = '0;
        rxd = 1'b1;
        rand_state = 32'd88;
        build_table();
        // each step fits in twelve bit periods.
        cycle_limit = steps.size() * 12 * CPB + 2000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < steps.size(); i++) begin
            apply_step(steps[i]);
        end
        wait_tx_idle();
        repeat (4) @(negedge clk);
        $display("errors: data_rd %0d, txd %0d, other %0d", data_errs, txd_errs, other_errs);
        if (data_errs + txd_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_controller.sv
sim/uart_checker.sv
sim/tb_uart.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the UART testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 --top-module tb_uart --timescale 1ns/1ps \
    -Mdir obj_dir -o sim_uart -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output="$(./obj_dir/sim_uart)"
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
